// ==== vlog.f ====
cache_geom_pkg.sv
fill_if_pkg.sv
cache_fill_fsm.sv
fill_arbiter.sv
cache_fill_top.sv
fill_props.sv
fill_checker.sv
tb_cache_fill.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the cache fill testbench with Verilator
# Exit status is 0 only when the pass line shows up in the simulation output
verilator --binary --timing --assert -Wno-fatal --top-module tb_cache_fill \
  -f vlog.f -o sim_tb \
  && ./obj_dir/sim_tb | tee /dev/stderr | grep -qx "all tests passed" \
  && echo "RESULT: PASS" && exit 0 \
  || { echo "RESULT: FAIL"; exit 1; }

// ==== tb_cache_fill.sv ====
/* Testbench for the miss-fill subsystem. Memory is a 4-stage delay line answering addr ^ key
   Each table row raises its misses and drops each one the cycle after its own tag write */
`timescale 1ns/1ns
`default_nettype none

module tb_cache_fill
  import cache_geom_pkg::*;
  import fill_if_pkg::*;
;
  localparam int          N_ROWS       = 12;
  localparam int          RESET_CYCLES = 8;
  localparam int          ROW_CYCLES   = 60;
  localparam int          CLK_NS       = 20;
  localparam int          WATCHDOG_NS  = (RESET_CYCLES + N_ROWS * ROW_CYCLES) * CLK_NS;
  localparam logic [15:0] DATA_KEY     = 16'ha5a5;

  typedef struct packed {
    logic        en_i;
    logic        en_d;
    logic [15:0] addr_i;
    logic [15:0] addr_d;
  } row_t;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        miss_i;
  logic        miss_d;
  cache_addr_u miss_addr_i;
  cache_addr_u miss_addr_d;
  mem_rsp_t    mem_rsp = '0;
  mem_req_t    mem_req;
  array_wr_t   wr_i;
  array_wr_t   wr_d;
  logic        busy_i;
  logic        busy_d;
  mem_rsp_t    mem_pipe [4];
  row_t        rows [N_ROWS];
  integer      seed;
  int          expected_fills;
  int          tests_run;
  int          tests_failed;
  int          errors;

  always #(CLK_NS / 2) clk = ~clk;

  // Memory model captures each request mid-cycle and answers 4 cycles later
  always @(negedge clk) begin
    if (!rst_n) begin
      mem_rsp <= '0;
      for (int k = 0; k < 4; k++) mem_pipe[k] <= '0;
    end else begin
      mem_rsp     <= mem_pipe[3];
      mem_pipe[3] <= mem_pipe[2];
      mem_pipe[2] <= mem_pipe[1];
      mem_pipe[1] <= mem_pipe[0];
      mem_pipe[0] <= {mem_req.rd, mem_req.addr ^ DATA_KEY};
    end
  end

  cache_fill_top dut0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .miss_i      (miss_i),
    .miss_d      (miss_d),
    .miss_addr_i (miss_addr_i),
    .miss_addr_d (miss_addr_d),
    .mem_rsp     (mem_rsp),
    .mem_req     (mem_req),
    .wr_i        (wr_i),
    .wr_d        (wr_d),
    .busy_i      (busy_i),
    .busy_d      (busy_d)
  );

  fill_checker chk0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .miss_i       (miss_i),
    .miss_d       (miss_d),
    .miss_addr_i  (miss_addr_i),
    .miss_addr_d  (miss_addr_d),
    .mem_req      (mem_req),
    .wr_i         (wr_i),
    .wr_d         (wr_d),
    .busy_i       (busy_i),
    .busy_d       (busy_d),
    .tests_run    (tests_run),
    .tests_failed (tests_failed),
    .errors       (errors)
  );

  // Directed rows lead and random rows follow with at least one miss each
  task automatic build_table();
    logic [31:0] r;
    rows[0] = '{en_i: 1'b1, en_d: 1'b0, addr_i: 16'h1236, addr_d: 16'h0000};
    rows[1] = '{en_i: 1'b0, en_d: 1'b1, addr_i: 16'h0000, addr_d: 16'h8a4c};
    rows[2] = '{en_i: 1'b1, en_d: 1'b1, addr_i: 16'h3ffe, addr_d: 16'h7002};
    for (int k = 3; k < N_ROWS; k++) begin
      r = $random(seed);
      rows[k].en_d = r[0];
      rows[k].en_i = r[1] | ~r[0];
      r = $random(seed);
      rows[k].addr_i = r[15:0];
      rows[k].addr_d = r[31:16];
    end
    expected_fills = 0;
    for (int k = 0; k < N_ROWS; k++) begin
      expected_fills += int'(rows[k].en_i) + int'(rows[k].en_d);
    end
  endtask

  // Starts and ends on a falling edge
  task automatic run_row(input row_t row);
    logic pend_i;
    logic pend_d;
    logic drop_i;
    logic drop_d;
    pend_i = row.en_i;
    pend_d = row.en_d;
    drop_i = 1'b0;
    drop_d = 1'b0;
    miss_addr_i.raw = row.addr_i;
    miss_addr_d.raw = row.addr_d;
    miss_i = row.en_i;
    miss_d = row.en_d;
    while (pend_i || pend_d || drop_i || drop_d) begin
      @(negedge clk);
      if (drop_i) begin
        miss_i = 1'b0;
        drop_i = 1'b0;
      end
      if (drop_d) begin
        miss_d = 1'b0;
        drop_d = 1'b0;
      end
      if (pend_i && wr_i.tag_we) begin  // Drop the miss one cycle after its tag write
        pend_i = 1'b0;
        drop_i = 1'b1;
      end
      if (pend_d && wr_d.tag_we) begin
        pend_d = 1'b0;
        drop_d = 1'b1;
      end
    end
    @(negedge clk);  // Idle gap between rows
  endtask

  initial begin
    seed            = 32'hc905_bc05;
    rst_n           = 1'b0;
    miss_i          = 1'b0;
    miss_d          = 1'b0;
    miss_addr_i.raw = '0;
    miss_addr_d.raw = '0;
    build_table();
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    repeat (3) @(negedge clk);  // Idle outputs after reset get checked here
    for (int k = 0; k < N_ROWS; k++) begin
      run_row(rows[k]);
    end
    repeat (10) @(negedge clk);
    $display("Fills checked %0d of %0d, failed %0d, other errors %0d",
             tests_run, expected_fills, tests_failed, errors);
    if (errors == 0 && tests_failed == 0 && tests_run == expected_fills) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Watchdog sized from the row count
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired at %0t, a fill never finished", $time);
    $display("tests failed");
    $finish;
  end

endmodule : tb_cache_fill

`default_nettype wire

// ==== fill_checker.sv ====
/* Watches the top ports only. Predicts the writes from the miss address and the memory key
   One line per completed fill; counts go back to the testbench */
`timescale 1ns/1ns
`default_nettype none

module fill_checker
  import cache_geom_pkg::*;
  import fill_if_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst_n,
  input  wire logic        miss_i,
  input  wire logic        miss_d,
  input  wire cache_addr_u miss_addr_i,
  input  wire cache_addr_u miss_addr_d,
  input  wire mem_req_t    mem_req,
  input  wire array_wr_t   wr_i,
  input  wire array_wr_t   wr_d,
  input  wire logic        busy_i,
  input  wire logic        busy_d,
  output int               tests_run,
  output int               tests_failed,
  output int               errors
);

  localparam logic [15:0] DATA_KEY = 16'ha5a5;

  logic        m [2];     // Index 0 is instruction and 1 is data
  cache_addr_u a [2];
  array_wr_t   w [2];
  logic        b [2];
  logic        miss_q [2];
  logic        pending [2];
  cache_addr_u blk [2];   // Predicted block base
  int          nwr [2];
  int          bad [2];
  int          rise [2];
  int          cyc;
  int          own;
  logic [15:0] exp_addr;
  logic        in_blk;
  string       side [2] = '{"wr_i", "wr_d"};

  always_comb begin
    m[0] = miss_i;
    m[1] = miss_d;
    a[0] = miss_addr_i;
    a[1] = miss_addr_d;
    w[0] = wr_i;
    w[1] = wr_d;
    b[0] = busy_i;
    b[1] = busy_d;
  end

  task automatic mismatch(input string sig, input logic [15:0] exp, input logic [15:0] act,
                          input int s);
    $display("MISMATCH t=%0t %s expected %h actual %h", $time, sig, exp, act);
    errors++;
    bad[s]++;
  endtask

  task automatic problem(input string msg, input int s);
    $display("ERROR t=%0t %s: %s", $time, side[s], msg);
    errors++;
    bad[s]++;
  endtask

  initial begin
    tests_run    = 0;
    tests_failed = 0;
    errors       = 0;
    cyc          = 0;
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      for (int s = 0; s < 2; s++) begin
        miss_q[s]  = 1'b0;
        pending[s] = 1'b0;
      end
    end else begin
      cyc++;
      // Data side has priority when its miss came no later
      if (w[0].data_we && pending[1] && rise[1] <= rise[0]) begin
        problem("instruction write before the pending data fill finished", 0);
      end
      // Earlier miss holds the port and data wins a tie
      own    = (pending[1] && !(pending[0] && rise[0] < rise[1])) ? 1 : 0;
      in_blk = pending[own] && mem_req.addr[15:4] == blk[own].f.tag;
      if (mem_req.rd && !in_blk) begin
        $display("ERROR t=%0t mem_req address %h outside the granted block",
                 $time, mem_req.addr);
        errors++;
      end
      for (int s = 0; s < 2; s++) begin
        if (b[s] !== m[s]) mismatch(s == 0 ? "busy_i" : "busy_d", {15'd0, m[s]}, {15'd0, b[s]}, s);
        if (m[s] && !miss_q[s]) begin
          pending[s]      = 1'b1;
          blk[s]          = a[s];
          blk[s].f.offset = '0;
          nwr[s]          = 0;
          bad[s]          = 0;
          rise[s]         = cyc;
        end
        if (w[s].data_we) begin
          if (!pending[s]) begin
            problem("data write with no fill pending", s);
          end else if (nwr[s] >= BLOCK_WORDS) begin
            problem("more than eight data writes", s);
          end else begin
            exp_addr = blk[s].raw + 16'(2 * nwr[s]);
            if (w[s].addr !== exp_addr) mismatch({side[s], ".addr"}, exp_addr, w[s].addr, s);
            if (w[s].data !== (exp_addr ^ DATA_KEY)) begin
              mismatch({side[s], ".data"}, exp_addr ^ DATA_KEY, w[s].data, s);
            end
            nwr[s]++;
          end
        end
        if (w[s].tag_we) begin
          if (!pending[s]) begin
            problem("tag write with no fill pending", s);
          end else begin
            if (nwr[s] != BLOCK_WORDS) begin
              problem($sformatf("tag write after only %0d data writes", nwr[s]), s);
            end
            if (w[s].tag !== blk[s].f.tag) begin
              mismatch({side[s], ".tag"}, {4'd0, blk[s].f.tag}, {4'd0, w[s].tag}, s);
            end
            $display("Fill %0d on %s block %h: %s", tests_run + 1, side[s], blk[s].raw,
                     bad[s] == 0 ? "PASS" : "FAIL");
            tests_run++;
            if (bad[s] != 0) tests_failed++;
            pending[s] = 1'b0;
          end
        end
        miss_q[s] = m[s];
      end
    end
  end

endmodule : fill_checker

`default_nettype wire

// ==== fill_props.sv ====
/* Concurrent checks on the grants, requests and write sequence inside the fill top
   Needs assertion support enabled in the simulator */
`timescale 1ns/1ns
`default_nettype none

module fill_props
  import fill_if_pkg::*;
(
  input wire logic      clk,
  input wire logic      rst_n,
  input wire logic      miss_d,
  input wire logic      grant_i,
  input wire logic      grant_d,
  input wire mem_req_t  req_i,
  input wire mem_req_t  req_d,
  input wire array_wr_t wr_i,
  input wire array_wr_t wr_d
);

  logic [3:0] nwr_i;  // Data writes since last tag write
  logic [3:0] nwr_d;

  always_ff @(posedge clk) begin
    if (!rst_n || wr_i.tag_we) nwr_i <= '0;
    else if (wr_i.data_we) nwr_i <= nwr_i + 1'b1;
    if (!rst_n || wr_d.tag_we) nwr_d <= '0;
    else if (wr_d.data_we) nwr_d <= nwr_d + 1'b1;
  end

  a_d_first: assert property (@(posedge clk) disable iff (!rst_n)
                              $rose(grant_i) |-> !$past(miss_d))
    else $error("instruction granted over a waiting data miss");
  a_req_i: assert property (@(posedge clk) disable iff (!rst_n) req_i.rd |-> grant_i)
    else $error("instruction request without grant");
  a_req_d: assert property (@(posedge clk) disable iff (!rst_n) req_d.rd |-> grant_d)
    else $error("data request without grant");
  a_tag_i: assert property (@(posedge clk) disable iff (!rst_n)
                            wr_i.tag_we |-> (nwr_i == 4'd8 && !wr_i.data_we))
    else $error("instruction tag write not after eight data writes");
  a_tag_d: assert property (@(posedge clk) disable iff (!rst_n)
                            wr_d.tag_we |-> (nwr_d == 4'd8 && !wr_d.data_we))
    else $error("data tag write not after eight data writes");

endmodule : fill_props

bind cache_fill_top fill_props props0 (
  .clk     (clk),
  .rst_n   (rst_n),
  .miss_d  (miss_d),
  .grant_i (grant_i),
  .grant_d (grant_d),
  .req_i   (req_i),
  .req_d   (req_d),
  .wr_i    (wr_i),
  .wr_d    (wr_d)
);

`default_nettype wire

// ==== cache_fill_top.sv ====
/* Miss-fill subsystem: instruction and data fill controllers on one read-only memory port
   Memory must return one word per request, in order, after a fixed latency of 1+ cycles */
`timescale 1ns/1ns
`default_nettype none

module cache_fill_top
  import cache_geom_pkg::*;
  import fill_if_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst_n,
  input  wire logic        miss_i,
  input  wire logic        miss_d,
  input  wire cache_addr_u miss_addr_i,
  input  wire cache_addr_u miss_addr_d,
  input  wire mem_rsp_t    mem_rsp,
  output mem_req_t         mem_req,
  output array_wr_t        wr_i,
  output array_wr_t        wr_d,
  output logic             busy_i,
  output logic             busy_d
);

  mem_req_t req_i;
  mem_req_t req_d;
  mem_rsp_t rsp_i;
  mem_rsp_t rsp_d;
  logic     grant_i;
  logic     grant_d;
  logic     done_i;
  logic     done_d;

  // Instruction side
  cache_fill_fsm fill_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .miss      (miss_i),
    .miss_addr (miss_addr_i),
    .grant     (grant_i),
    .rsp       (rsp_i),
    .req       (req_i),
    .wr        (wr_i),
    .busy      (busy_i),
    .done      (done_i)
  );

  // Data side
  cache_fill_fsm fill_d (
    .clk       (clk),
    .rst_n     (rst_n),
    .miss      (miss_d),
    .miss_addr (miss_addr_d),
    .grant     (grant_d),
    .rsp       (rsp_d),
    .req       (req_d),
    .wr        (wr_d),
    .busy      (busy_d),
    .done      (done_d)
  );

  fill_arbiter arb0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .miss_i  (miss_i),
    .miss_d  (miss_d),
    .done_i  (done_i),
    .done_d  (done_d),
    .req_i   (req_i),
    .req_d   (req_d),
    .mem_rsp (mem_rsp),
    .grant_i (grant_i),
    .grant_d (grant_d),
    .mem_req (mem_req),
    .rsp_i   (rsp_i),
    .rsp_d   (rsp_d)
  );

endmodule : cache_fill_top

`default_nettype wire

// ==== fill_arbiter.sv ====
/* Single memory port shared by two fill controllers, data side wins ties
   A granted fill is never preempted; the grant is released the cycle after done */
`timescale 1ns/1ns
`default_nettype none

module fill_arbiter
  import fill_if_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     rst_n,
  input  wire logic     miss_i,
  input  wire logic     miss_d,
  input  wire logic     done_i,
  input  wire logic     done_d,
  input  wire mem_req_t req_i,
  input  wire mem_req_t req_d,
  input  wire mem_rsp_t mem_rsp,
  output logic          grant_i,
  output logic          grant_d,
  output mem_req_t      mem_req,
  output mem_rsp_t      rsp_i,
  output mem_rsp_t      rsp_d
);

  fill_sel_e owner;
  fill_sel_e owner_nxt;

  // Fixed priority, only chosen from idle
  always_comb begin
    owner_nxt = owner;
    case (owner)
      SEL_NONE: begin
        if (miss_d) begin
          owner_nxt = SEL_DCACHE;
        end else if (miss_i) begin
          owner_nxt = SEL_ICACHE;
        end
      end
      SEL_ICACHE: if (done_i) owner_nxt = SEL_NONE;
      SEL_DCACHE: if (done_d) owner_nxt = SEL_NONE;
      default:    owner_nxt = SEL_NONE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      owner <= SEL_NONE;
    end else begin
      owner <= owner_nxt;
    end
  end

  assign grant_i = (owner == SEL_ICACHE);
  assign grant_d = (owner == SEL_DCACHE);

  // Owner's request goes out, idle port drives nothing
  always_comb begin
    case (owner)
      SEL_ICACHE: mem_req = req_i;
      SEL_DCACHE: mem_req = req_d;
      default:    mem_req = '0;
    endcase
  end

  // Data fans out to both, valid only to the owner
  always_comb begin
    rsp_i       = mem_rsp;
    rsp_i.valid = mem_rsp.valid & grant_i;
    rsp_d       = mem_rsp;
    rsp_d.valid = mem_rsp.valid & grant_d;
  end

endmodule : fill_arbiter

`default_nettype wire

// ==== cache_fill_fsm.sv ====
/* Block fill for one cache: 8 requests, 8 data writes on valid responses, then tag write
   Miss must stay high until the tag write; dropping it early abandons the fill */
`timescale 1ns/1ns
`default_nettype none

module cache_fill_fsm
  import cache_geom_pkg::*;
  import fill_if_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst_n,
  input  wire logic        miss,
  input  wire cache_addr_u miss_addr,
  input  wire logic        grant,
  input  wire mem_rsp_t    rsp,
  output mem_req_t         req,
  output array_wr_t        wr,
  output logic             busy,
  output logic             done
);

  localparam logic [CNT_W-1:0] LAST_REQ = CNT_W'(BLOCK_WORDS);
  localparam logic [CNT_W-1:0] REQ_DONE = LAST_REQ + 1'b1;
  localparam logic [WORD_W-1:0] STEP    = WORD_W'(WORD_BYTES);

  logic [CNT_W-1:0] req_cnt;   // 0 load base, 1..8 strobe, 9 spent
  logic [CNT_W-1:0] ret_cnt;   // Words returned so far
  cache_addr_u      req_addr;  // Next memory address
  cache_addr_u      wr_addr;   // Next data array address
  cache_addr_u      base;
  logic             active;
  logic             first;
  logic             req_fire;
  logic             ret_fire;
  logic             tag_fire;

  // Block base is the miss address with the offset cleared
  always_comb begin
    base          = miss_addr;
    base.f.offset = '0;
  end

  assign active   = miss & grant;
  assign first    = active & (req_cnt == '0);
  assign req_fire = active & (req_cnt != '0) & (req_cnt <= LAST_REQ);
  assign ret_fire = active & rsp.valid & (ret_cnt != LAST_REQ);
  assign tag_fire = active & (ret_cnt == LAST_REQ);  // Cycle after 8th word

  // Request sequencing advances every granted cycle
  always_ff @(posedge clk) begin
    if (!rst_n || !active) begin
      req_cnt <= '0;
    end else if (req_cnt != REQ_DONE) begin
      req_cnt <= req_cnt + 1'b1;
    end
  end

  // Returned words only count on valid responses
  always_ff @(posedge clk) begin
    if (!rst_n || !active || tag_fire) begin
      ret_cnt <= '0;
    end else if (ret_fire) begin
      ret_cnt <= ret_cnt + 1'b1;
    end
  end

  // Request address, stops on base+14 so the tag field stays valid
  always_ff @(posedge clk) begin
    if (first) begin
      req_addr <= base;
    end else if (req_fire && (req_cnt != LAST_REQ)) begin
      req_addr.raw <= req_addr.raw + STEP;
    end
  end

  // Write address follows the responses, not the requests
  always_ff @(posedge clk) begin
    if (first) begin
      wr_addr <= base;
    end else if (ret_fire && (ret_cnt != LAST_REQ - 1'b1)) begin
      wr_addr.raw <= wr_addr.raw + STEP;
    end
  end

  always_comb begin
    req.rd   = req_fire;
    req.addr = req_addr.raw;
  end

  // Data write rides the response cycle
  always_comb begin
    wr.data_we = ret_fire;
    wr.addr    = wr_addr.raw;
    wr.data    = rsp.data;
    wr.tag_we  = tag_fire;
    wr.tag     = req_addr.f.tag;  // Latched block, not the live miss address
  end

  assign busy = miss;
  assign done = tag_fire;

endmodule : cache_fill_fsm

`default_nettype wire

// ==== fill_if_pkg.sv ====
/* Bus payloads between fill controllers, arbiter, memory and cache arrays
   Strobes are single-cycle, no ready or stall anywhere */
`default_nettype none

package fill_if_pkg;

  import cache_geom_pkg::*;

  // Read request to memory, one word per strobe
  typedef struct packed {
    logic              rd;
    logic [WORD_W-1:0] addr;      // Byte address
  } mem_req_t;

  // Memory answer, in request order
  typedef struct packed {
    logic              valid;
    logic [WORD_W-1:0] data;
  } mem_rsp_t;

  // Write port into one cache's data and tag arrays
  typedef struct packed {
    logic              data_we;
    logic [WORD_W-1:0] addr;
    logic [WORD_W-1:0] data;
    logic              tag_we;
    logic [TAG_W-1:0]  tag;
  } array_wr_t;

  // Current owner of the memory port
  typedef enum logic [1:0] {
    SEL_NONE   = 2'd0,
    SEL_ICACHE = 2'd1,
    SEL_DCACHE = 2'd2
  } fill_sel_e;

endpackage : fill_if_pkg

`default_nettype wire

// ==== cache_geom_pkg.sv ====
/* Fixed cache geometry: 16-bit byte addresses, 16-byte blocks of eight 16-bit words
   Nothing here is tunable per instance */
`default_nettype none

package cache_geom_pkg;

  // Word and address width
  localparam int WORD_W      = 16;
  localparam int WORD_BYTES  = WORD_W / 8;   // Byte step between words

  // Block layout
  localparam int BLOCK_WORDS = 8;
  localparam int OFFSET_W    = 4;            // 16 bytes per block
  localparam int TAG_W       = WORD_W - OFFSET_W;

  // Fill counters must reach BLOCK_WORDS + 1
  localparam int CNT_W       = 4;

  // Field view of an address
  typedef struct packed {
    logic [TAG_W-1:0]    tag;
    logic [OFFSET_W-1:0] offset;
  } cache_addr_s;

  // One address word, read raw for arithmetic or split into tag and offset
  typedef union packed {
    logic [WORD_W-1:0] raw;
    cache_addr_s       f;
  } cache_addr_u;

endpackage : cache_geom_pkg

`default_nettype wire
